/* clr_prng.f */
+incdir+rtl
rtl/clr_prng_pkg.sv
rtl/seed_packer.sv
rtl/clearing_prng.sv
rtl/rand_fifo.sv
rtl/wipe_ctrl.sv
rtl/clr_prng_top.sv
verif/clr_prng_tb.sv

/* rtl/clearing_prng.sv */
// Credit-gated clearing PRNG with a Galois LFSR, a PRINCE S-box layer and a
// rotated second share, reseeded from the entropy port through the seed packer.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module clearing_prng (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [`CLR_ENT_WIDTH-1:0] entropy_i,
  input  logic                      credit_return_i,
  output logic                      push_o,
  output logic [`CLR_WIDTH-1:0]     push_share0_o,
  output logic [`CLR_WIDTH-1:0]     push_share1_o
);
  import clr_prng_pkg::*;

  localparam int unsigned CredW = $clog2(`CLR_FIFO_DEPTH + 1);

  logic [`CLR_WIDTH-1:0] lfsr_q;
  logic [`CLR_WIDTH-1:0] lfsr_step;
  logic [`CLR_WIDTH-1:0] share0;
  logic [CredW-1:0]      credit_q;
  logic [CredW-1:0]      credit_d;
  logic                  seed_valid;
  logic [`CLR_WIDTH-1:0] seed;

  // PRINCE 4-bit S-box.
  function automatic logic [3:0] sbox4(input logic [3:0] x);
    logic [3:0] y;
    case (x)
      4'h0: y = 4'hB;
      4'h1: y = 4'hF;
      4'h2: y = 4'h3;
      4'h3: y = 4'h2;
      4'h4: y = 4'hA;
      4'h5: y = 4'hC;
      4'h6: y = 4'h9;
      4'h7: y = 4'h1;
      4'h8: y = 4'h6;
      4'h9: y = 4'h7;
      4'hA: y = 4'h8;
      4'hB: y = 4'h0;
      4'hC: y = 4'hE;
      4'hD: y = 4'h5;
      4'hE: y = 4'hD;
      default: y = 4'h4;
    endcase
    return y;
  endfunction

  seed_packer u_seed_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (reseed_req_i),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .seed_valid_o  (seed_valid),
    .seed_o        (seed)
  );

  // Push whenever the FIFO has room for us and no reseed is waiting.
  // A pending reseed freezes the LFSR so the new seed never races a step.
  // The load cycle counts as pending too, since the old state is about to be replaced.
  assign push_o = (credit_q != '0) && !reseed_req_i && !seed_valid;

  // Nonlinear layer over every nibble of the current state.
  always_comb begin
    for (int i = 0; i < `CLR_WIDTH / 4; i++) begin
      share0[4*i +: 4] = sbox4(lfsr_q[4*i +: 4]);
    end
  end

  assign push_share0_o = share0;
  assign push_share1_o = (share0 << `CLR_SHARE_ROT) | (share0 >> (`CLR_WIDTH - `CLR_SHARE_ROT));

  // Galois step that shifts right and folds the taps back in when a one falls out.
  assign lfsr_step = {1'b0, lfsr_q[`CLR_WIDTH-1:1]} ^ (lfsr_q[0] ? `CLR_LFSR_TAPS : '0);

  // Push and credit return may coincide, and then the count stays put.
  assign credit_d = credit_q - CredW'(push_o) + CredW'(credit_return_i);

  // The seed loads in the cycle it is presented, which is also the ack cycle.
  assign reseed_ack_o = seed_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= `CLR_LFSR_SEED;
      credit_q <= CredW'(`CLR_FIFO_DEPTH);
    end else begin
      credit_q <= credit_d;
      if (seed_valid) begin
        // An all-zero seed would lock up the LFSR.
        lfsr_q <= (seed == '0) ? `CLR_LFSR_SEED : seed;
      end else if (push_o) begin
        lfsr_q <= lfsr_step;
      end
    end
  end

  // Credits must never exceed the FIFO depth, else the FIFO could overflow.
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CredW'(`CLR_FIFO_DEPTH));

  a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lfsr_q != '0);

  // Half a seed only exists while the environment still holds its reseed request.
  a_half_seed_only_in_reseed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (u_seed_packer.state_q == SEED_HALF) |-> reseed_req_i);

endmodule

`default_nettype wire

/* rtl/clr_prng_defines.svh */
// Clearing PRNG shared widths, depths and generator constants.
// Included by every RTL block of the secure-wipe subsystem.
`ifndef CLR_PRNG_DEFINES_SVH
`define CLR_PRNG_DEFINES_SVH

// Width of one random share and of the LFSR state.
`define CLR_WIDTH 64

// Width of one beat on the entropy port.
`define CLR_ENT_WIDTH 32

// Depth of the share-pair buffer, which is also the initial credit count.
`define CLR_FIFO_DEPTH 4

// Number of register-file entries the wipe controller overwrites.
`define CLR_NUM_REGS 8

// Address width of the register file.
`define CLR_ADDR_W 3

// Galois feedback mask, XORed in whenever a one is shifted out.
`define CLR_LFSR_TAPS 64'hD800000000000000

// Seed used at reset and whenever an all-zero seed arrives.
`define CLR_LFSR_SEED 64'h0123456789ABCDEF

// Left rotation that turns share 0 into share 1.
`define CLR_SHARE_ROT 13

`endif

/* rtl/clr_prng_pkg.sv */
// Clearing PRNG package with the state encodings used by the RTL.
`default_nettype none

package clr_prng_pkg;

  // Seed packer state.
  // The packer either waits for the first entropy beat or already holds it.
  typedef enum logic {
    SEED_EMPTY = 1'b0,
    SEED_HALF  = 1'b1
  } seed_state_e;

  // Wipe controller state.
  // IDLE accepts register writes and wipe requests.
  // RUN drains the FIFO into the register file, one entry per pop.
  // DONE lasts a single cycle and produces the done pulse.
  typedef enum logic [1:0] {
    WIPE_IDLE = 2'd0,
    WIPE_RUN  = 2'd1,
    WIPE_DONE = 2'd2
  } wipe_state_e;

endpackage

`default_nettype wire

/* rtl/clr_prng_top.sv */
// Secure-wipe subsystem top: clearing PRNG feeding a share-pair FIFO
// that the wipe controller drains into its register file.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module clr_prng_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [`CLR_ENT_WIDTH-1:0] entropy_i,
  input  logic                      reseed_req_i,
  output logic                      reseed_ack_o,
  input  logic                      wipe_req_i,
  output logic                      wipe_busy_o,
  output logic                      wipe_done_o,
  input  logic                      wr_en_i,
  input  logic [`CLR_ADDR_W-1:0]    wr_addr_i,
  input  logic [`CLR_WIDTH-1:0]     wr_share0_i,
  input  logic [`CLR_WIDTH-1:0]     wr_share1_i,
  input  logic [`CLR_ADDR_W-1:0]    rd_addr_i,
  output logic [`CLR_WIDTH-1:0]     rd_share0_o,
  output logic [`CLR_WIDTH-1:0]     rd_share1_o
);

  // Producer to buffer, credit based.
  logic                  push;
  logic [`CLR_WIDTH-1:0] push_share0;
  logic [`CLR_WIDTH-1:0] push_share1;
  logic                  credit_return;

  // Buffer to consumer.
  logic                  fifo_valid;
  logic [`CLR_WIDTH-1:0] fifo_share0;
  logic [`CLR_WIDTH-1:0] fifo_share1;
  logic                  pop;

  clearing_prng u_clearing_prng (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reseed_req_i    (reseed_req_i),
    .reseed_ack_o    (reseed_ack_o),
    .entropy_req_o   (entropy_req_o),
    .entropy_ack_i   (entropy_ack_i),
    .entropy_i       (entropy_i),
    .credit_return_i (credit_return),
    .push_o          (push),
    .push_share0_o   (push_share0),
    .push_share1_o   (push_share1)
  );

  rand_fifo #(
    .DEPTH (`CLR_FIFO_DEPTH)
  ) u_rand_fifo (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .share0_i        (push_share0),
    .share1_i        (push_share1),
    .pop_i           (pop),
    .valid_o         (fifo_valid),
    .share0_o        (fifo_share0),
    .share1_o        (fifo_share1),
    .credit_return_o (credit_return)
  );

  wipe_ctrl u_wipe_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wipe_req_i    (wipe_req_i),
    .wipe_busy_o   (wipe_busy_o),
    .wipe_done_o   (wipe_done_o),
    .wr_en_i       (wr_en_i),
    .wr_addr_i     (wr_addr_i),
    .wr_share0_i   (wr_share0_i),
    .wr_share1_i   (wr_share1_i),
    .rd_addr_i     (rd_addr_i),
    .rd_share0_o   (rd_share0_o),
    .rd_share1_o   (rd_share1_o),
    .fifo_valid_i  (fifo_valid),
    .fifo_share0_i (fifo_share0),
    .fifo_share1_i (fifo_share1),
    .pop_o         (pop)
  );

endmodule

`default_nettype wire

/* rtl/rand_fifo.sv */
// Share-pair FIFO between generator and wipe controller.
// Every pop hands one credit back to the generator on the next cycle.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module rand_fifo #(
  parameter int unsigned DEPTH = `CLR_FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  logic [`CLR_WIDTH-1:0] share0_i,
  input  logic [`CLR_WIDTH-1:0] share1_i,
  input  logic                  pop_i,
  output logic                  valid_o,
  output logic [`CLR_WIDTH-1:0] share0_o,
  output logic [`CLR_WIDTH-1:0] share1_o,
  output logic                  credit_return_o
);

  // DEPTH is a power of two, so the pointers wrap on their own.
  localparam int unsigned PtrW = $clog2(DEPTH);
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  logic [`CLR_WIDTH-1:0] mem0 [DEPTH];
  logic [`CLR_WIDTH-1:0] mem1 [DEPTH];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q        <= '0;
      rd_ptr_q        <= '0;
      count_q         <= '0;
      credit_return_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q         <= count_q + CntW'(push_i) - CntW'(pop_i);
      // One credit per popped entry, registered.
      credit_return_o <= pop_i;
    end
  end

  // Storage only, the pointers decide what is valid.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem0[wr_ptr_q] <= share0_i;
      mem1[wr_ptr_q] <= share1_i;
    end
  end

  // The head pair is shown as soon as the FIFO holds anything.
  assign valid_o  = (count_q != '0);
  assign share0_o = mem0[rd_ptr_q];
  assign share1_o = mem1[rd_ptr_q];

  // The generator's credit count must keep it from ever filling past DEPTH.
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q < CntW'(DEPTH)) || pop_i);

  // The consumer only pops what it has seen as valid.
  a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (count_q != '0));

endmodule

`default_nettype wire

/* rtl/seed_packer.sv */
// Seed packer that gathers two entropy beats into one LFSR seed.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module seed_packer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [`CLR_ENT_WIDTH-1:0] entropy_i,
  output logic                      seed_valid_o,
  output logic [`CLR_WIDTH-1:0]     seed_o
);
  import clr_prng_pkg::*;

  seed_state_e               state_q;
  logic                      accept;
  logic [`CLR_ENT_WIDTH-1:0] beat_q;
  logic [`CLR_WIDTH-1:0]     seed_q;
  logic                      seed_valid_q;

  // Keep requesting while a reseed is pending and no complete seed is on its way out.
  // The request drops in the cycle the seed is presented, so no third beat is taken.
  assign entropy_req_o = start_i && !seed_valid_q;

  // A beat moves only when both sides agree in the same cycle.
  assign accept = entropy_req_o && entropy_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SEED_EMPTY;
      seed_valid_q <= 1'b0;
    end else begin
      seed_valid_q <= 1'b0;
      if (accept) begin
        if (state_q == SEED_EMPTY) begin
          state_q <= SEED_HALF;
        end else begin
          // Second beat completes the seed, it is valid for one cycle.
          state_q      <= SEED_EMPTY;
          seed_valid_q <= 1'b1;
        end
      end
    end
  end

  // First beat lands in the low half, second beat in the high half.
  always_ff @(posedge clk_i) begin
    if (accept && state_q == SEED_EMPTY) begin
      beat_q <= entropy_i;
    end
    if (accept && state_q == SEED_HALF) begin
      seed_q <= {entropy_i, beat_q};
    end
  end

  assign seed_valid_o = seed_valid_q;
  assign seed_o       = seed_q;

endmodule

`default_nettype wire

/* rtl/wipe_ctrl.sv */
// Wipe controller with a register file of share pairs and load and read ports,
// overwritten entry by entry from the FIFO on a wipe request.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module wipe_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wipe_req_i,
  output logic                   wipe_busy_o,
  output logic                   wipe_done_o,
  input  logic                   wr_en_i,
  input  logic [`CLR_ADDR_W-1:0] wr_addr_i,
  input  logic [`CLR_WIDTH-1:0]  wr_share0_i,
  input  logic [`CLR_WIDTH-1:0]  wr_share1_i,
  input  logic [`CLR_ADDR_W-1:0] rd_addr_i,
  output logic [`CLR_WIDTH-1:0]  rd_share0_o,
  output logic [`CLR_WIDTH-1:0]  rd_share1_o,
  input  logic                   fifo_valid_i,
  input  logic [`CLR_WIDTH-1:0]  fifo_share0_i,
  input  logic [`CLR_WIDTH-1:0]  fifo_share1_i,
  output logic                   pop_o
);
  import clr_prng_pkg::*;

  localparam logic [`CLR_ADDR_W-1:0] LastAddr = `CLR_ADDR_W'(`CLR_NUM_REGS - 1);

  wipe_state_e            state_q;
  logic [`CLR_ADDR_W-1:0] addr_q;
  logic [`CLR_WIDTH-1:0]  regs0 [`CLR_NUM_REGS];
  logic [`CLR_WIDTH-1:0]  regs1 [`CLR_NUM_REGS];
  logic                   sw_write;

  // Take one pair whenever the FIFO has one and we are wiping.
  assign pop_o = (state_q == WIPE_RUN) && fifo_valid_i;

  // Software writes are dropped while the wipe walks the file.
  assign sw_write = wr_en_i && (state_q != WIPE_RUN);

  assign wipe_busy_o = (state_q == WIPE_RUN);
  assign wipe_done_o = (state_q == WIPE_DONE);

  // Wipe FSM.
  // The address walks 0 to the last entry, stepping only on a pop.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WIPE_IDLE;
      addr_q  <= '0;
    end else begin
      case (state_q)
        WIPE_IDLE: begin
          if (wipe_req_i) begin
            state_q <= WIPE_RUN;
            addr_q  <= '0;
          end
        end
        WIPE_RUN: begin
          if (pop_o) begin
            if (addr_q == LastAddr) begin
              state_q <= WIPE_DONE;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        WIPE_DONE: begin
          // Done is a single-cycle pulse.
          state_q <= WIPE_IDLE;
        end
        default: begin
          state_q <= WIPE_IDLE;
        end
      endcase
    end
  end

  // Register file.
  // It reads as zero after reset. A wipe pop takes priority over software.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CLR_NUM_REGS; i++) begin
        regs0[i] <= '0;
        regs1[i] <= '0;
      end
    end else if (pop_o) begin
      regs0[addr_q] <= fifo_share0_i;
      regs1[addr_q] <= fifo_share1_i;
    end else if (sw_write) begin
      regs0[wr_addr_i] <= wr_share0_i;
      regs1[wr_addr_i] <= wr_share1_i;
    end
  end

  // Reads are combinational.
  assign rd_share0_o = regs0[rd_addr_i];
  assign rd_share1_o = regs1[rd_addr_i];

endmodule

`default_nettype wire

/* verif/clr_prng_tb.sv */
// Directed testbench for the secure-wipe subsystem.
// A software generator model predicts every share pair that a wipe writes.
`timescale 1ns/1ps
`include "clr_prng_defines.svh"
`default_nettype none

module clr_prng_tb;

  // PRINCE S-box, input 0 in the top nibble and input F in the bottom nibble.
  localparam logic [63:0] sbox_table = 64'hBF32AC916780E5D4;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      entropy_req_o;
  logic                      entropy_ack_i;
  logic [`CLR_ENT_WIDTH-1:0] entropy_i;
  logic                      reseed_req_i;
  logic                      reseed_ack_o;
  logic                      wipe_req_i;
  logic                      wipe_busy_o;
  logic                      wipe_done_o;
  logic                      wr_en_i;
  logic [`CLR_ADDR_W-1:0]    wr_addr_i;
  logic [`CLR_WIDTH-1:0]     wr_share0_i;
  logic [`CLR_WIDTH-1:0]     wr_share1_i;
  logic [`CLR_ADDR_W-1:0]    rd_addr_i;
  logic [`CLR_WIDTH-1:0]     rd_share0_o;
  logic [`CLR_WIDTH-1:0]     rd_share1_o;

  // The model holds the LFSR value of the next push and the pairs the FIFO holds.
  logic [`CLR_WIDTH-1:0] model_state;
  logic [127:0]          pair_q [$];
  // Expected register file after the wipe under test, share 1 in the upper half.
  logic [127:0]          expected_regs [`CLR_NUM_REGS];
  int                    fail_count;

  clr_prng_top clr_prng_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .wipe_req_i    (wipe_req_i),
    .wipe_busy_o   (wipe_busy_o),
    .wipe_done_o   (wipe_done_o),
    .wr_en_i       (wr_en_i),
    .wr_addr_i     (wr_addr_i),
    .wr_share0_i   (wr_share0_i),
    .wr_share1_i   (wr_share1_i),
    .rd_addr_i     (rd_addr_i),
    .rd_share0_o   (rd_share0_o),
    .rd_share1_o   (rd_share1_o)
  );

  // 40 ns clock period.
  always #20 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    fail_count++;
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t: %s got 0x%h, expected 0x%h", $time, name, got, expected);
      abort_run("A checked value did not match its expected value.");
    end
  endtask

  // Inputs change 2 ns after the rising edge, well away from the sampling edge.
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // Share 0 is the S-box applied to every nibble of the state.
  function automatic logic [63:0] substitute_nibbles(input logic [63:0] state);
    logic [63:0] r;
    int          idx;
    for (int n = 0; n < 16; n++) begin
      idx = int'(state[4*n +: 4]);
      r[4*n +: 4] = sbox_table[60 - 4*idx +: 4];
    end
    return r;
  endfunction

  // Bit i of share 0 lands at bit i plus the rotation, wrapping past the top.
  function automatic logic [63:0] rotate_share(input logic [63:0] x);
    logic [63:0] r;
    for (int i = 0; i < 64; i++) begin
      r[(i + `CLR_SHARE_ROT) % 64] = x[i];
    end
    return r;
  endfunction

  // Shift right, then fold in the taps if a one fell out.
  function automatic logic [63:0] galois_step(input logic [63:0] s);
    logic        out_bit;
    logic [63:0] r;
    out_bit = s[0];
    r = s >> 1;
    if (out_bit) begin
      r = r ^ `CLR_LFSR_TAPS;
    end
    return r;
  endfunction

  // One push of the generator emits the pair of the current state and then steps.
  task automatic produce_pair();
    logic [63:0] s0;
    s0 = substitute_nibbles(model_state);
    pair_q.push_back({rotate_share(s0), s0});
    model_state = galois_step(model_state);
  endtask

  task automatic write_entry(input int addr, input logic [63:0] s0, input logic [63:0] s1);
    wr_en_i     = 1'b1;
    wr_addr_i   = `CLR_ADDR_W'(addr);
    wr_share0_i = s0;
    wr_share1_i = s1;
    next_cycle();
    wr_en_i = 1'b0;
  endtask

  // Reads are combinational, so a short settle delay is enough.
  task automatic read_entry(input int addr, output logic [63:0] s0, output logic [63:0] s1);
    rd_addr_i = `CLR_ADDR_W'(addr);
    #1;
    s0 = rd_share0_o;
    s1 = rd_share1_o;
  endtask

  task automatic start_wipe();
    wipe_req_i = 1'b1;
    next_cycle();
    wipe_req_i = 1'b0;
    check_value("wipe_busy_o", wipe_busy_o, 1);
  endtask

  // Waits for the done pulse and compares every entry with expected_regs.
  // With scribble set, random writes are issued for as long as the wipe is busy.
  task automatic finish_wipe(input bit scribble);
    logic [63:0] s0;
    logic [63:0] s1;
    int          cycles;
    cycles = 0;
    while (!wipe_done_o) begin
      if (cycles == 200) begin
        abort_run("Timeout: wipe_done_o never pulsed after the wipe request.");
      end
      if (scribble && wipe_busy_o) begin
        write_entry(int'($urandom_range(7, 0)), {$urandom, $urandom}, {$urandom, $urandom});
      end else begin
        next_cycle();
      end
      cycles++;
    end
    wr_en_i = 1'b0;
    // Done must be a single pulse and busy must be gone with it.
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      check_value("wipe_done_o", wipe_done_o, 0);
      check_value("wipe_busy_o", wipe_busy_o, 0);
    end
    for (int a = 0; a < `CLR_NUM_REGS; a++) begin
      read_entry(a, s0, s1);
      check_value("rd_share0_o", s0, expected_regs[a][63:0]);
      check_value("rd_share1_o", s1, expected_regs[a][127:64]);
    end
  endtask

  // Runs one wipe from a full FIFO and compares every entry with the model.
  task automatic run_wipe();
    idle_cycles(10);
    // Each pop returns a credit, which the generator spends on one more push.
    for (int a = 0; a < `CLR_NUM_REGS; a++) begin
      expected_regs[a] = pair_q.pop_front();
      produce_pair();
    end
    start_wipe();
    finish_wipe(1'b0);
  endtask

  // Delivers two entropy beats after random gaps and waits for the reseed ack.
  // The reseed request must already be high.
  task automatic feed_entropy(input logic [31:0] beat0, input logic [31:0] beat1);
    logic [31:0] beat;
    logic [63:0] seed;
    int          cycles;
    for (int k = 0; k < 2; k++) begin
      beat = (k == 0) ? beat0 : beat1;
      cycles = 0;
      next_cycle();
      while (!entropy_req_o) begin
        if (cycles == 200) begin
          abort_run("Timeout: entropy_req_o never rose during the reseed.");
        end
        next_cycle();
        cycles++;
      end
      idle_cycles(int'($urandom_range(3, 0)));
      entropy_i     = beat;
      entropy_ack_i = 1'b1;
      next_cycle();
      entropy_ack_i = 1'b0;
      entropy_i     = '0;
    end
    cycles = 0;
    while (!reseed_ack_o) begin
      if (cycles == 200) begin
        abort_run("Timeout: reseed_ack_o never pulsed after the second entropy beat.");
      end
      next_cycle();
      cycles++;
    end
    check_value("entropy_req_o", entropy_req_o, 0);
    reseed_req_i = 1'b0;
    next_cycle();
    check_value("reseed_ack_o", reseed_ack_o, 0);
    // FIFO entries stay and only later pushes follow the new seed.
    seed = {beat1, beat0};
    model_state = (seed == '0) ? `CLR_LFSR_SEED : seed;
  endtask

  task automatic do_reseed(input logic [31:0] beat0, input logic [31:0] beat1);
    idle_cycles(10);
    reseed_req_i = 1'b1;
    feed_entropy(beat0, beat1);
  endtask

  // A pending reseed stops the generator, so the wipe drains the four buffered
  // pairs and then waits on an empty FIFO while random writes hit the wiped entries.
  task automatic scribble_wipe_test(input logic [31:0] beat0, input logic [31:0] beat1);
    idle_cycles(10);
    reseed_req_i = 1'b1;
    for (int a = 0; a < `CLR_FIFO_DEPTH; a++) begin
      expected_regs[a] = pair_q.pop_front();
    end
    start_wipe();
    for (int i = 0; i < 12; i++) begin
      write_entry(int'($urandom_range(`CLR_FIFO_DEPTH - 1, 0)),
                  {$urandom, $urandom}, {$urandom, $urandom});
    end
    check_value("wipe_busy_o", wipe_busy_o, 1);
    feed_entropy(beat0, beat1);
    // The rest of the file comes from the new seed, then the FIFO refills.
    for (int a = `CLR_FIFO_DEPTH; a < `CLR_NUM_REGS; a++) begin
      produce_pair();
      expected_regs[a] = pair_q.pop_front();
    end
    repeat (`CLR_FIFO_DEPTH) produce_pair();
    finish_wipe(1'b1);
  endtask

  task automatic reset_state_test();
    logic [63:0] s0;
    logic [63:0] s1;
    check_value("entropy_req_o", entropy_req_o, 0);
    check_value("reseed_ack_o", reseed_ack_o, 0);
    check_value("wipe_done_o", wipe_done_o, 0);
    check_value("wipe_busy_o", wipe_busy_o, 0);
    for (int a = 0; a < `CLR_NUM_REGS; a++) begin
      read_entry(a, s0, s1);
      check_value("rd_share0_o", s0, 0);
      check_value("rd_share1_o", s1, 0);
    end
  endtask

  task automatic load_read_test();
    logic [63:0] data0 [`CLR_NUM_REGS];
    logic [63:0] data1 [`CLR_NUM_REGS];
    logic [63:0] s0;
    logic [63:0] s1;
    for (int a = 0; a < `CLR_NUM_REGS; a++) begin
      data0[a] = {$urandom, $urandom};
      data1[a] = {$urandom, $urandom};
      write_entry(a, data0[a], data1[a]);
    end
    for (int a = 0; a < `CLR_NUM_REGS; a++) begin
      read_entry(a, s0, s1);
      check_value("rd_share0_o", s0, data0[a]);
      check_value("rd_share1_o", s1, data1[a]);
    end
  endtask

  initial begin
    void'($urandom(61));
    fail_count    = 0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    entropy_ack_i = 1'b0;
    entropy_i     = '0;
    reseed_req_i  = 1'b0;
    wipe_req_i    = 1'b0;
    wr_en_i       = 1'b0;
    wr_addr_i     = '0;
    wr_share0_i   = '0;
    wr_share1_i   = '0;
    rd_addr_i     = '0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // After reset the generator fills the FIFO with four pairs from the reset seed.
    model_state = `CLR_LFSR_SEED;
    repeat (`CLR_FIFO_DEPTH) produce_pair();

    reset_state_test();
    load_read_test();
    run_wipe();
    do_reseed($urandom, $urandom);
    run_wipe();
    do_reseed('0, '0);
    run_wipe();
    scribble_wipe_test($urandom, $urandom);

    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
